//--- rtl/ex_pkg.sv
package ex_pkg;

  //////////////////////////////////////////////////
  // Architectural sizes
  //////////////////////////////////////////////////

  localparam int unsigned XLEN     = 32;
  localparam int unsigned NUM_REGS = 32;

  // Data word and register index
  typedef logic [XLEN-1:0]             word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  // ALU operation codes
  typedef enum logic [4:0] {
    ADD  = 5'd0,
    SUB  = 5'd1,
    AND  = 5'd2,
    OR   = 5'd3,
    XOR  = 5'd4,
    SLL  = 5'd5,
    SRL  = 5'd6,
    SRA  = 5'd7,
    SLT  = 5'd8,
    SLTU = 5'd9,
    // Branch comparisons
    EQ   = 5'd10,
    NE   = 5'd11,
    LT   = 5'd12,
    GE   = 5'd13,
    LTU  = 5'd14,
    GEU  = 5'd15
  } alu_op_e;

  // Lane split of the adder
  typedef enum logic [1:0] {
    VEC_32 = 2'b00,
    VEC_16 = 2'b10,
    VEC_8  = 2'b11
  } vec_mode_e;

  //////////////////////////////////////////////////
  // Bundles between stages
  //////////////////////////////////////////////////

  // Multiplier control
  // Bit 0 of sel_subword and signed_mode refers to a, bit 1 to b
  typedef struct packed {
    logic       en;
    logic [1:0] sel_subword;
    logic [1:0] signed_mode;
    logic       mac_en;
  } mult_ctrl_t;

  // One decoded operation as held in ID/EX
  typedef struct packed {
    alu_op_e    alu_op;
    vec_mode_e  vec_mode;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    mult_ctrl_t mult;
    reg_addr_t  alu_waddr;
    logic       alu_we;
    logic       prepost_useincr;
    logic       wb_we;
    reg_addr_t  wb_waddr;
    word_t      rb_data;
    logic       hwloop_sel;
    word_t      hwloop_pc_plus4;
    word_t      hwloop_cnt;
    logic       csr_access;
    word_t      csr_rdata;
  } id_ex_t;

  // Register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     data;
  } wb_port_t;

  // Forward path towards decode
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     data;
  } fwd_port_t;

  // Hardware loop register setup
  typedef struct packed {
    word_t start;
    word_t end_addr;
    word_t cnt;
  } hwloop_data_t;

endpackage

//--- rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu
(
  input  ex_pkg::alu_op_e   operator_i,
  input  ex_pkg::word_t     operand_a_i,
  input  ex_pkg::word_t     operand_b_i,
  input  ex_pkg::vec_mode_e vec_mode_i,
  output ex_pkg::word_t     adder_o,
  output ex_pkg::word_t     result_o,
  output logic              flag_o
);

  import ex_pkg::*;

  // Operation classes
  logic        is_cmp;
  logic        is_sub;
  logic        cmp_signed;
  vec_mode_e   lane_mode;

  // Lane adder with one separator bit per byte edge
  logic [2:0]  sep_a;
  logic [2:0]  sep_b;
  word_t       operand_b_inv;
  logic [35:0] add_in_a;
  logic [35:0] add_in_b;
  logic [35:0] add_sum;
  word_t       lane_result;

  // Comparator
  logic        is_equal;
  logic        is_less;

  // Shifter
  logic        shift_left;
  logic [4:0]  shamt;
  word_t       operand_a_rev;
  word_t       shift_in;
  logic [XLEN:0] shift_wide;
  word_t       shift_right;
  word_t       shift_left_res;

  //////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////

  assign is_cmp     = operator_i inside {SLT, SLTU, EQ, NE, LT, GE, LTU, GEU};
  assign is_sub     = (operator_i == SUB) || is_cmp;
  assign cmp_signed = operator_i inside {SLT, LT, GE};

  // Compares always see a single full-width lane
  assign lane_mode  = is_cmp ? VEC_32 : vec_mode_i;

  // Separator pair 1/0 passes the carry on
  // Pair 0/0 kills it for add, pair 1/1 injects the +1 of the next lane for sub
  always_comb
  begin
    case (lane_mode)
      VEC_16:
      begin
        sep_a = {1'b1, is_sub, 1'b1};
        sep_b = {1'b0, is_sub, 1'b0};
      end
      VEC_8:
      begin
        sep_a = {3{is_sub}};
        sep_b = {3{is_sub}};
      end
      default:
      begin
        sep_a = 3'b111;
        sep_b = 3'b000;
      end
    endcase
  end

  assign operand_b_inv = is_sub ? ~operand_b_i : operand_b_i;

  // Bit 0 carries the +1 of lane 0 for sub
  assign add_in_a = {operand_a_i[31:24], sep_a[2], operand_a_i[23:16], sep_a[1],
                     operand_a_i[15:8], sep_a[0], operand_a_i[7:0], 1'b1};
  assign add_in_b = {operand_b_inv[31:24], sep_b[2], operand_b_inv[23:16], sep_b[1],
                     operand_b_inv[15:8], sep_b[0], operand_b_inv[7:0], is_sub};

  assign add_sum     = add_in_a + add_in_b;
  assign lane_result = {add_sum[35:28], add_sum[26:19], add_sum[17:10], add_sum[8:1]};

  // Plain sum for the load/store address
  assign adder_o = operand_a_i + operand_b_i;

  //////////////////////////////////////////////////
  // Comparator on the shared subtract
  //////////////////////////////////////////////////

  assign is_equal = (lane_result == '0);

  // Equal MSBs cannot overflow so the difference sign decides
  assign is_less = (operand_a_i[XLEN-1] == operand_b_i[XLEN-1]) ? lane_result[XLEN-1] :
                   (cmp_signed ? operand_a_i[XLEN-1] : operand_b_i[XLEN-1]);

  always_comb
  begin
    case (operator_i)
      EQ:                flag_o = is_equal;
      NE:                flag_o = ~is_equal;
      SLT, SLTU, LT, LTU: flag_o = is_less;
      GE, GEU:           flag_o = ~is_less;
      default:           flag_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  assign shift_left = (operator_i == SLL);
  assign shamt      = operand_b_i[4:0];

  // Left shift runs through the right shifter on reversed bits
  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
    begin
      operand_a_rev[i]  = operand_a_i[XLEN-1-i];
      shift_left_res[i] = shift_right[XLEN-1-i];
    end
  end

  assign shift_in    = shift_left ? operand_a_rev : operand_a_i;
  assign shift_wide  = $signed({(operator_i == SRA) & operand_a_i[XLEN-1], shift_in}) >>> shamt;
  assign shift_right = shift_wide[XLEN-1:0];

  // Result select
  always_comb
  begin
    case (operator_i)
      ADD, SUB: result_o = lane_result;
      AND:      result_o = operand_a_i & operand_b_i;
      OR:       result_o = operand_a_i | operand_b_i;
      XOR:      result_o = operand_a_i ^ operand_b_i;
      SLL:      result_o = shift_left_res;
      SRL, SRA: result_o = shift_right;
      default:  result_o = {{(XLEN-1){1'b0}}, flag_o};
    endcase
  end

endmodule

//--- rtl/ex_mult.sv
`timescale 1ns/1ps

module ex_mult
(
  input  ex_pkg::mult_ctrl_t ctrl_i,
  input  ex_pkg::word_t      op_a_i,
  input  ex_pkg::word_t      op_b_i,
  input  ex_pkg::word_t      mac_i,
  output ex_pkg::word_t      result_o
);

  import ex_pkg::*;

  logic        subword;

  // Selected halfwords
  logic [15:0] half_a;
  logic [15:0] half_b;

  // Extended subword operands
  word_t       sub_a;
  word_t       sub_b;

  // Operands into the single 32x32 array
  word_t       mul_a;
  word_t       mul_b;
  word_t       product;
  word_t       acc;

  //////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////

  // Any halfword select switches to the 16x16 form
  assign subword = |ctrl_i.sel_subword;

  // Upper or lower halfword of each source
  assign half_a = ctrl_i.sel_subword[0] ? op_a_i[31:16] : op_a_i[15:0];
  assign half_b = ctrl_i.sel_subword[1] ? op_b_i[31:16] : op_b_i[15:0];

  // Sign or zero extension per operand
  assign sub_a = {{16{ctrl_i.signed_mode[0] & half_a[15]}}, half_a};
  assign sub_b = {{16{ctrl_i.signed_mode[1] & half_b[15]}}, half_b};

  // Idle multiplier sees zero operands so the array does not toggle
  always_comb
  begin
    if (!ctrl_i.en)
    begin
      mul_a = '0;
      mul_b = '0;
    end
    else if (subword)
    begin
      mul_a = sub_a;
      mul_b = sub_b;
    end
    else
    begin
      mul_a = op_a_i;
      mul_b = op_b_i;
    end
  end

  //////////////////////////////////////////////////
  // Product and accumulate
  //////////////////////////////////////////////////

  // Low 32 bits of the product
  // A 16x16 product of extended halves fits fully in these bits
  assign product = mul_a * mul_b;

  // Accumulator input only for MAC
  assign acc = (ctrl_i.en && ctrl_i.mac_en) ? mac_i : '0;

  assign result_o = product + acc;

endmodule

//--- rtl/id_ex_pipe.sv
`timescale 1ns/1ps

module id_ex_pipe
(
  input  logic           clk,
  input  logic           rst_n,
  input  ex_pkg::id_ex_t op_i,
  input  logic           issue_i,
  input  logic           stall_ex_i,
  output ex_pkg::id_ex_t op_o
);

  import ex_pkg::*;

  id_ex_t bubble;
  id_ex_t op_q;

  // Bubble keeps the payload but drops every write and side effect
  always_comb
  begin
    bubble            = op_i;
    bubble.alu_we     = 1'b0;
    bubble.wb_we      = 1'b0;
    bubble.mult.en    = 1'b0;
    bubble.csr_access = 1'b0;
  end

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      // Empty slot after reset
      op_q <= '0;
    end
    else if (!stall_ex_i)
    begin
      if (issue_i)
      begin
        op_q <= op_i;
      end
      else
      begin
        op_q <= bubble;
      end
    end
  end

  assign op_o = op_q;

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  ex_pkg::id_ex_t       op_i,
  input  logic                 stall_wb_i,
  output ex_pkg::fwd_port_t    fwd_o,
  output ex_pkg::wb_port_t     wb_o,
  output ex_pkg::word_t        data_addr_o,
  output ex_pkg::hwloop_data_t hwloop_o,
  output ex_pkg::word_t        jump_target_o,
  output logic                 branch_decision_o
);

  import ex_pkg::*;

  // Unit results
  word_t    alu_result;
  word_t    alu_adder;
  logic     alu_flag;
  word_t    mult_result;

  // Port 2 fields into EX/WB
  wb_port_t wb_d;
  wb_port_t wb_q;

  ex_alu alu_i
  (
    .operator_i  ( op_i.alu_op    ),
    .operand_a_i ( op_i.operand_a ),
    .operand_b_i ( op_i.operand_b ),
    .vec_mode_i  ( op_i.vec_mode  ),
    .adder_o     ( alu_adder      ),
    .result_o    ( alu_result     ),
    .flag_o      ( alu_flag       )
  );

  ex_mult mult_i
  (
    .ctrl_i   ( op_i.mult      ),
    .op_a_i   ( op_i.operand_a ),
    .op_b_i   ( op_i.operand_b ),
    .mac_i    ( op_i.operand_c ),
    .result_o ( mult_result    )
  );

  //////////////////////////////////////////////////
  // Forward port
  //////////////////////////////////////////////////

  // CSR read beats multiplier, multiplier beats ALU
  always_comb
  begin
    fwd_o.we    = op_i.alu_we;
    fwd_o.waddr = op_i.alu_waddr;
    if (op_i.csr_access)
      fwd_o.data = op_i.csr_rdata;
    else if (op_i.mult.en)
      fwd_o.data = mult_result;
    else
      fwd_o.data = alu_result;
  end

  // Post-increment uses the computed sum
  assign data_addr_o = op_i.prepost_useincr ? alu_adder : op_i.operand_a;

  // Hardware loop setup
  assign hwloop_o.start    = op_i.hwloop_sel ? alu_result : op_i.hwloop_pc_plus4;
  assign hwloop_o.end_addr = alu_result;
  assign hwloop_o.cnt      = op_i.hwloop_cnt;

  assign jump_target_o     = op_i.operand_c;
  assign branch_decision_o = alu_flag;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  assign wb_d.we    = op_i.wb_we;
  assign wb_d.waddr = op_i.wb_waddr;
  assign wb_d.data  = op_i.rb_data;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      wb_q <= '0;
    else if (!stall_wb_i)
      wb_q <= wb_d;
  end

  assign wb_o = wb_q;

endmodule

//--- rtl/ex_top.sv
`timescale 1ns/1ps

module ex_top
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  ex_pkg::id_ex_t       op_i,
  input  logic                 issue_i,
  input  logic                 stall_ex_i,
  input  logic                 stall_wb_i,
  output ex_pkg::fwd_port_t    fwd_o,
  output ex_pkg::wb_port_t     wb_o,
  output ex_pkg::word_t        data_addr_o,
  output ex_pkg::hwloop_data_t hwloop_o,
  output ex_pkg::word_t        jump_target_o,
  output logic                 branch_decision_o
);

  import ex_pkg::*;

  // Operation in flight through execute
  id_ex_t id_ex_q;

  id_ex_pipe id_ex_pipe_i
  (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .op_i       ( op_i       ),
    .issue_i    ( issue_i    ),
    .stall_ex_i ( stall_ex_i ),
    .op_o       ( id_ex_q    )
  );

  ex_stage ex_stage_i
  (
    .clk               ( clk               ),
    .rst_n             ( rst_n             ),
    .op_i              ( id_ex_q           ),
    .stall_wb_i        ( stall_wb_i        ),
    .fwd_o             ( fwd_o             ),
    .wb_o              ( wb_o              ),
    .data_addr_o       ( data_addr_o       ),
    .hwloop_o          ( hwloop_o          ),
    .jump_target_o     ( jump_target_o     ),
    .branch_decision_o ( branch_decision_o )
  );

endmodule

//--- bench/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top;

  import ex_pkg::*;

  localparam int CLK_PERIOD = 8;

  // Expected outputs of one test line
  typedef struct packed {
    word_t    fwd_data;
    logic     flag;
    word_t    data_addr;
    word_t    hwloop_start;
    wb_port_t wb;
  } expect_t;

  logic         clk;
  logic         rst_n;
  id_ex_t       op_i;
  logic         issue_i;
  logic         stall_ex_i;
  logic         stall_wb_i;
  fwd_port_t    fwd_o;
  wb_port_t     wb_o;
  word_t        data_addr_o;
  hwloop_data_t hwloop_o;
  word_t        jump_target_o;
  logic         branch_decision_o;

  // Vectors from the data file
  id_ex_t       test_ops[$];
  expect_t      test_exp[$];
  logic         loaded;

  logic [15:0]  lfsr_state;
  int           err_count;
  int           pass_count;
  int           fail_count;

  ex_top ex_top_i
  (
    .clk               ( clk               ),
    .rst_n             ( rst_n             ),
    .op_i              ( op_i              ),
    .issue_i           ( issue_i           ),
    .stall_ex_i        ( stall_ex_i        ),
    .stall_wb_i        ( stall_wb_i        ),
    .fwd_o             ( fwd_o             ),
    .wb_o              ( wb_o              ),
    .data_addr_o       ( data_addr_o       ),
    .hwloop_o          ( hwloop_o          ),
    .jump_target_o     ( jump_target_o     ),
    .branch_decision_o ( branch_decision_o )
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0])
      next = next ^ 16'hb400;
    return next;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bit(output logic b);
    b          = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  task automatic compare_value(input int idx, input string what, input word_t got,
                               input word_t exp);
    if (got !== exp)
    begin
      $display("FAIL t=%0t test %0d: %s got %h expected %h", $time, idx, what, got, exp);
      err_count++;
    end
  endtask

  // Columns 0..16 are the op, 17..23 the expected values
  task automatic load_tests();
    int          fd;
    int          n;
    int          code;
    string       line;
    logic [31:0] col [24];
    id_ex_t      op;
    expect_t     exp;
    fd = $fopen("bench/ex_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open bench/ex_tests.txt");
      err_count++;
      return;
    end
    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      if (code > 0)
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                    col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
        // Comment and blank lines do not give a full record
        if (n == 24)
        begin
          op                 = '0;
          op.alu_op          = alu_op_e'(col[0][4:0]);
          op.vec_mode        = vec_mode_e'(col[1][1:0]);
          op.operand_a       = col[2];
          op.operand_b       = col[3];
          op.operand_c       = col[4];
          op.mult            = mult_ctrl_t'(col[5][5:0]);
          op.alu_we          = col[6][0];
          op.alu_waddr       = col[7][4:0];
          op.prepost_useincr = col[8][0];
          op.wb_we           = col[9][0];
          op.wb_waddr        = col[10][4:0];
          op.rb_data         = col[11];
          op.hwloop_sel      = col[12][0];
          op.hwloop_pc_plus4 = col[13];
          op.hwloop_cnt      = col[14];
          op.csr_access      = col[15][0];
          op.csr_rdata       = col[16];
          exp.fwd_data       = col[17];
          exp.flag           = col[18][0];
          exp.data_addr      = col[19];
          exp.hwloop_start   = col[20];
          exp.wb.we          = col[21][0];
          exp.wb.waddr       = col[22][4:0];
          exp.wb.data        = col[23];
          test_ops.push_back(op);
          test_exp.push_back(exp);
        end
      end
    end
    $fclose(fd);
  endtask

  // Outputs that follow the ID/EX register directly
  task automatic check_comb_outputs(input int idx, input id_ex_t op, input expect_t exp);
    compare_value(idx, "fwd data", fwd_o.data, exp.fwd_data);
    compare_value(idx, "fwd we", word_t'(fwd_o.we), word_t'(op.alu_we));
    compare_value(idx, "fwd waddr", word_t'(fwd_o.waddr), word_t'(op.alu_waddr));
    compare_value(idx, "branch flag", word_t'(branch_decision_o), word_t'(exp.flag));
    compare_value(idx, "jump target", jump_target_o, op.operand_c);
    compare_value(idx, "data addr", data_addr_o, exp.data_addr);
    compare_value(idx, "hwloop start", hwloop_o.start, exp.hwloop_start);
    compare_value(idx, "hwloop cnt", hwloop_o.cnt, op.hwloop_cnt);
    // End address is the ALU result as seen through start or a plain ALU forward
    if (op.hwloop_sel)
      compare_value(idx, "hwloop end", hwloop_o.end_addr, exp.hwloop_start);
    if (!op.csr_access && !op.mult.en)
      compare_value(idx, "hwloop end", hwloop_o.end_addr, exp.fwd_data);
  endtask

  //////////////////////////////////////////////////
  // One vector through issue, execute and writeback
  //////////////////////////////////////////////////

  task automatic run_test(input int idx);
    id_ex_t    op;
    expect_t   exp;
    logic      hold_ex;
    logic      hold_wb;
    int        errs_before;
    fwd_port_t fwd_seen;
    wb_port_t  wb_seen;
    op          = test_ops[idx];
    exp         = test_exp[idx];
    errs_before = err_count;
    draw_bit(hold_ex);
    draw_bit(hold_wb);

    @(posedge clk);
    #1;
    op_i    = op;
    issue_i = 1'b1;

    // A held writeback also holds execute so the op is not lost
    @(posedge clk);
    #1;
    issue_i    = 1'b0;
    stall_ex_i = hold_ex | hold_wb;
    stall_wb_i = hold_wb;
    @(negedge clk);
    check_comb_outputs(idx, op, exp);
    fwd_seen = fwd_o;
    wb_seen  = wb_o;

    if (hold_ex | hold_wb)
    begin
      @(posedge clk);
      #1;
      stall_ex_i = 1'b0;
      stall_wb_i = 1'b0;
      @(negedge clk);
      if (fwd_o !== fwd_seen)
      begin
        $display("FAIL t=%0t test %0d: fwd_o changed under stall_ex", $time, idx);
        err_count++;
      end
      check_comb_outputs(idx, op, exp);
      if (hold_wb && wb_o !== wb_seen)
      begin
        $display("FAIL t=%0t test %0d: wb_o changed under stall_wb", $time, idx);
        err_count++;
      end
    end

    // Writeback port one cycle after execute with a bubble behind it
    @(posedge clk);
    @(negedge clk);
    compare_value(idx, "wb we", word_t'(wb_o.we), word_t'(exp.wb.we));
    compare_value(idx, "wb waddr", word_t'(wb_o.waddr), word_t'(exp.wb.waddr));
    compare_value(idx, "wb data", wb_o.data, exp.wb.data);
    compare_value(idx, "bubble fwd we", word_t'(fwd_o.we), '0);

    if (err_count == errs_before)
    begin
      $display("test %0d: ok (stall_ex %0b stall_wb %0b)", idx, hold_ex, hold_wb);
      pass_count++;
    end
    else
    begin
      $display("test %0d: %0d mismatches", idx, err_count - errs_before);
      fail_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    rst_n      = 1'b0;
    op_i       = '0;
    issue_i    = 1'b0;
    stall_ex_i = 1'b0;
    stall_wb_i = 1'b0;
    lfsr_state = 16'd60;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    loaded     = 1'b0;
    load_tests();
    loaded = 1'b1;
    if (test_ops.size() == 0)
    begin
      $display("No test vectors were read");
      err_count++;
    end

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    // Both write enables must come out of reset low
    if (wb_o.we !== 1'b0 || fwd_o.we !== 1'b0)
    begin
      $display("FAIL t=%0t reset: write enable high after reset", $time);
      err_count++;
    end

    for (int i = 0; i < test_ops.size(); i++)
      run_test(i);

    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             test_ops.size(), pass_count, fail_count, err_count);
    if (err_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // Ten cycles per vector plus the reset time
  initial
  begin
    wait (loaded);
    #((test_ops.size() * 10 + 5) * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles",
             test_ops.size() * 10 + 5);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- bench/ex_tests.txt
# op vm a b c mult alu_we alu_waddr incr wb_we wb_waddr rb_data hwl_sel pc4 hwl_cnt csr csr_rdata
# then expected fwd_data flag data_addr hwl_start wb_we wb_waddr wb_data, all hex
0 0 7fffffff 00000001 0 00 1 05 1 1 06 11 0 100 3 0 0 80000000 0 80000000 100 1 06 11
1 0 00000005 00000007 0 00 1 1f 0 0 02 abcd 1 104 0 0 0 fffffffe 0 00000005 fffffffe 0 02 abcd
2 0 f0f0ff00 0ff0f0f0 0 00 0 03 1 1 07 1234 0 200 1 0 0 00f0f000 0 00e1eff0 200 1 07 1234
4 0 ffff0000 0f0f0f0f 0 00 1 04 0 1 08 5 1 108 2 0 0 f0f00f0f 0 ffff0000 f0f00f0f 1 08 5
5 0 00000081 00000024 0 00 1 09 1 0 09 0 0 10c 4 0 0 00000810 0 000000a5 10c 0 09 0
7 0 80000010 00000004 0 00 1 0a 0 1 0a 77 1 110 5 0 0 f8000001 0 80000010 f8000001 1 0a 77
8 0 ffffffff 00000001 0 00 1 0b 0 0 0b 0 0 114 6 0 0 00000001 1 ffffffff 114 0 0b 0
9 0 ffffffff 00000001 0 00 1 0c 0 0 0c 0 0 118 7 0 0 00000000 0 ffffffff 118 0 0c 0
0 2 0001ffff 00010001 0 00 1 0d 1 1 0d 3 1 11c 8 0 0 00020000 0 00030000 00020000 1 0d 3
1 2 00000005 00010006 0 00 1 0e 0 1 0e 4 0 120 9 0 0 ffffffff 0 00000005 120 1 0e 4
0 3 ff7f80ff 01010101 0 00 1 0f 1 0 0f 0 1 124 a 0 0 00808100 0 00808200 00808100 0 0f 0
1 3 00100305 01020304 0 00 1 10 0 1 10 6 0 128 b 0 0 ff0e0001 0 00100305 128 1 10 6
a 0 00001234 00001234 00000400 00 0 11 0 0 11 0 1 12c c 0 0 00000001 1 00001234 00000001 0 11 0
b 0 00001234 00001235 00000404 00 0 12 0 0 12 0 0 130 d 0 0 00000001 1 00001234 130 0 12 0
c 0 80000000 00000001 00000408 00 0 13 0 0 13 0 0 134 e 0 0 00000001 1 80000000 134 0 13 0
d 0 80000000 00000001 0000040c 00 0 14 0 0 14 0 0 138 f 0 0 00000000 0 80000000 138 0 14 0
e 0 80000000 00000001 00000410 00 0 15 0 0 15 0 0 13a 1 0 0 00000000 0 80000000 13a 0 15 0
f 0 80000000 00000001 00000414 00 0 16 1 0 16 0 0 13b 1 0 0 00000001 1 80000001 13b 0 16 0
0 0 00010003 00020005 0 20 1 17 1 1 17 77 1 13c 2 0 0 000b000f 0 00030008 00030008 1 17 77
0 0 fffe0000 00030000 0 3e 1 18 0 1 18 8 0 140 1 0 0 fffffffa 0 fffe0000 140 1 18 8
0 0 ffff0000 0000ffff 0 2a 1 19 0 0 19 0 1 144 1 0 0 ffff0001 0 ffff0000 ffffffff 0 19 0
0 0 0000ffff ffff0000 0 30 1 1a 1 1 1a 9 0 148 1 0 0 fffe0001 0 ffffffff 148 1 1a 9
0 0 00000003 00000004 00000100 21 1 1b 0 1 1b a 1 14c 1 0 0 0000010c 0 00000003 00000007 1 1b a
0 0 fffd0000 00000004 00000020 2f 1 1c 0 0 1c 0 0 150 1 0 0 00000014 0 fffd0000 150 0 1c 0
0 0 00000003 00000004 00000100 21 1 1d 0 1 1d b 1 154 1 1 1800 00001800 0 00000003 00000007 1 1d b
1 0 00000009 00000002 0 00 1 1e 1 0 1e 0 0 158 1 1 55aa 000055aa 0 0000000b 158 0 1e 0

//--- vlog.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/id_ex_pipe.sv
rtl/ex_stage.sv
rtl/ex_top.sv
bench/tb_ex_top.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - rtl/ex_pkg.sv
  - rtl/ex_alu.sv
  - rtl/ex_mult.sv
  - rtl/id_ex_pipe.sv
  - rtl/ex_stage.sv
  - rtl/ex_top.sv
  - target: test
    files:
      - bench/tb_ex_top.sv
